// ==== design/scope_pkg.sv ====
`default_nettype none

package scope_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths and sizes
  //////////////////////////////////////////////////////////////////////

  localparam int SAMPLE_W  = 14;    // converted sample, also dac code
  localparam int RAW_W     = 16;    // adc port word
  localparam int RAW_LSB   = 2;     // low 2 bits reserved on 16 bit adc
  localparam int BUF_DEPTH = 1024;  // capture window, pairs
  localparam int ADDR_W    = 10;    // log2 of BUF_DEPTH

  //////////////////////////////////////////////////////////////////////
  // types
  //////////////////////////////////////////////////////////////////////

  // adc word as seen on the pins
  typedef logic [RAW_W-1:0] raw_word_t;

  // offset code, negative slope (adc after input reg, dac at the pins)
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  typedef logic signed [SAMPLE_W-1:0] sample_t;  // two's complement

  // buffer address, post trigger length
  typedef logic [ADDR_W-1:0] buf_addr_t;

  // capture sequence
  typedef enum logic [2:0] {
    IDLE,       // waiting for arm
    FILL,       // pre-trigger part of the window
    WAIT_TRIG,  // keep writing, look for the crossing
    POST,       // post-trigger part, trigger pair first
    DONE        // window frozen until readout finishes
  } cap_state_t;

  typedef enum logic {
    RD_IDLE,
    RD_RUN
  } rd_state_t;

endpackage

`default_nettype wire

// ==== design/analog_io.sv ====
`default_nettype none

module analog_io (
  input  wire                      adc_clk,
  input  wire                      rst_n_i,
  // adc pins
  input  wire scope_pkg::raw_word_t adc_a_i,         // ch a, low bits unused
  input  wire scope_pkg::raw_word_t adc_b_i,         // ch b
  // dac samples from the generator side
  input  wire scope_pkg::sample_t   dac_a_i,
  input  wire scope_pkg::sample_t   dac_b_i,
  input  wire                      digital_loop_i,  // dac replaces adc
  // towards capture
  output scope_pkg::sample_t        sample_a_o,
  output scope_pkg::sample_t        sample_b_o,
  // dac pins
  output scope_pkg::dac_code_t      dac_a_o,
  output scope_pkg::dac_code_t      dac_b_o
);

  //////////////////////////////////////////////////////////////////////
  // code conversion
  //////////////////////////////////////////////////////////////////////

  // msb kept, the rest inverted
  // same operation in both directions: neg slope offset <-> two's compl
  function automatic scope_pkg::dac_code_t flip_code(input scope_pkg::dac_code_t v);
    flip_code = {v[scope_pkg::SAMPLE_W-1], ~v[scope_pkg::SAMPLE_W-2:0]};
  endfunction

  // first stage
  scope_pkg::dac_code_t adc_a_q;  // raw code, upper 14 bits
  scope_pkg::dac_code_t adc_b_q;
  scope_pkg::sample_t   dac_a_q;  // dac sample, feeds pins and loopback
  scope_pkg::sample_t   dac_b_q;

  //////////////////////////////////////////////////////////////////////
  // stage 1, input registers
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_a_q <= '0;
      adc_b_q <= '0;
      dac_a_q <= '0;  // dac sits at midscale code after reset
      dac_b_q <= '0;
    end
    else
    begin
      // lowest 2 bits reserved
      adc_a_q <= adc_a_i[scope_pkg::RAW_W-1:scope_pkg::RAW_LSB];
      adc_b_q <= adc_b_i[scope_pkg::RAW_W-1:scope_pkg::RAW_LSB];
      dac_a_q <= dac_a_i;
      dac_b_q <= dac_b_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stage 2, conversion or loopback
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sample_a_o <= '0;
      sample_b_o <= '0;
    end
    else if (digital_loop_i)
    begin
      // dac path already signed, same 2 cycle latency as the adc path
      sample_a_o <= dac_a_q;
      sample_b_o <= dac_b_q;
    end
    else
    begin
      sample_a_o <= scope_pkg::sample_t'(flip_code(adc_a_q));
      sample_b_o <= scope_pkg::sample_t'(flip_code(adc_b_q));
    end
  end

  // dac pins, signed -> offset neg slope
  // one cycle from dac_*_i
  assign dac_a_o = flip_code(dac_a_q);
  assign dac_b_o = flip_code(dac_b_q);

endmodule

`default_nettype wire

// ==== design/capture_buffer.sv ====
`default_nettype none

module capture_buffer (
  input  wire                      adc_clk,
  input  wire                      rst_n_i,
  // one pair per cycle from the front end
  input  wire scope_pkg::sample_t   sample_a_i,
  input  wire scope_pkg::sample_t   sample_b_i,
  // trigger setup
  input  wire scope_pkg::sample_t   trig_level_i,  // rising crossing on ch a
  input  wire scope_pkg::buf_addr_t post_len_i,    // pairs from trigger on, >= 1
  input  wire                      arm_i,         // pulse, only taken in IDLE
  // readout side
  input  wire scope_pkg::buf_addr_t rd_addr_i,
  input  wire                      rd_finish_i,   // last beat out, release window
  output logic                     done_o,
  output scope_pkg::buf_addr_t      start_addr_o,  // oldest entry
  output scope_pkg::sample_t        rd_a_o,        // 1 cycle after rd_addr_i
  output scope_pkg::sample_t        rd_b_o
);

  // two channel memory
  scope_pkg::sample_t    mem_a [scope_pkg::BUF_DEPTH];
  scope_pkg::sample_t    mem_b [scope_pkg::BUF_DEPTH];

  scope_pkg::cap_state_t state;
  scope_pkg::buf_addr_t  wr_ptr;     // next free slot, wraps
  scope_pkg::buf_addr_t  pair_cnt;   // shared by FILL and POST
  scope_pkg::buf_addr_t  fill_last;  // last FILL count
  scope_pkg::buf_addr_t  post_last;  // last POST count
  scope_pkg::sample_t    pair_a_q;   // pair going into memory
  scope_pkg::sample_t    pair_b_q;
  logic                  wr_en;
  logic                  trig_hit;

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  // pre-trigger length = BUF_DEPTH - post_len
  assign fill_last = scope_pkg::buf_addr_t'(scope_pkg::BUF_DEPTH - 1 - int'(post_len_i));
  assign post_last = post_len_i - 1'b1;

  assign wr_en = (state == scope_pkg::FILL) ||
                 (state == scope_pkg::WAIT_TRIG) ||
                 (state == scope_pkg::POST);

  // incoming pair delayed by one, so the pair that completes a crossing
  // is still ahead of the memory when it is detected
  always_ff @(posedge adc_clk)
  begin
    pair_a_q <= sample_a_i;
    pair_b_q <= sample_b_i;
  end

  // level crossing, previous below and current at or above
  assign trig_hit = (pair_a_q < trig_level_i) && (sample_a_i >= trig_level_i);

  always_ff @(posedge adc_clk)
  begin
    if (wr_en)
    begin
      mem_a[wr_ptr] <= pair_a_q;
      mem_b[wr_ptr] <= pair_b_q;
    end
    // registered read, block ram style
    rd_a_o <= mem_a[rd_addr_i];
    rd_b_o <= mem_b[rd_addr_i];
  end

  //////////////////////////////////////////////////////////////////////
  // capture FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state    <= scope_pkg::IDLE;
      wr_ptr   <= '0;
      pair_cnt <= '0;
    end
    else
    begin
      if (wr_en)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at BUF_DEPTH
      case (state)
        scope_pkg::IDLE:
        begin
          pair_cnt <= '0;
          if (arm_i)
            state <= scope_pkg::FILL;
        end
        scope_pkg::FILL:
        begin
          pair_cnt <= pair_cnt + 1'b1;
          if (pair_cnt == fill_last)
          begin
            pair_cnt <= '0;  // reused for POST
            state    <= scope_pkg::WAIT_TRIG;
          end
        end
        scope_pkg::WAIT_TRIG:
        begin
          if (trig_hit)
            state <= scope_pkg::POST;  // trigger pair is the next write
        end
        scope_pkg::POST:
        begin
          pair_cnt <= pair_cnt + 1'b1;
          if (pair_cnt == post_last)
            state <= scope_pkg::DONE;
        end
        scope_pkg::DONE:
        begin
          if (rd_finish_i)
            state <= scope_pkg::IDLE;
        end
        default:
          state <= scope_pkg::IDLE;
      endcase
    end
  end

  assign done_o       = (state == scope_pkg::DONE);
  assign start_addr_o = wr_ptr;  // frozen in DONE, points at the oldest pair

  // window can only complete out of the post trigger phase
  a_done_from_post: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $rose(done_o) |-> $past(state) == scope_pkg::POST);

  // readout must not release a window that is not there
  a_finish_in_done: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    rd_finish_i |-> state == scope_pkg::DONE);

endmodule

`default_nettype wire

// ==== design/capture_readout.sv ====
`default_nettype none

module capture_readout (
  input  wire                      adc_clk,
  input  wire                      rst_n_i,
  input  wire                      done_i,        // window ready
  input  wire scope_pkg::buf_addr_t start_addr_i,  // oldest pair
  output scope_pkg::buf_addr_t      rd_addr_o,
  output logic                     rd_valid_o,    // data from memory this cycle
  output logic                     rd_last_o      // last beat, also the release
);

  scope_pkg::rd_state_t state;
  scope_pkg::buf_addr_t rd_addr_q;
  scope_pkg::buf_addr_t issue_cnt;   // addresses issued so far
  logic                 issue;       // address on rd_addr_o is a real read
  logic                 issue_last;

  //////////////////////////////////////////////////////////////////////
  // address issue
  //////////////////////////////////////////////////////////////////////

  assign issue      = (state == scope_pkg::RD_RUN);
  assign issue_last = issue &&
                      (issue_cnt == scope_pkg::buf_addr_t'(scope_pkg::BUF_DEPTH - 1));
  assign rd_addr_o  = rd_addr_q;

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      state      <= scope_pkg::RD_IDLE;
      rd_addr_q  <= '0;
      issue_cnt  <= '0;
      rd_valid_o <= 1'b0;
      rd_last_o  <= 1'b0;
    end
    else
    begin
      // memory answers one cycle later
      rd_valid_o <= issue;
      rd_last_o  <= issue_last;
      case (state)
        scope_pkg::RD_IDLE:
        begin
          // done is still up while the last beat goes out
          if (done_i && !rd_last_o)
          begin
            state     <= scope_pkg::RD_RUN;
            rd_addr_q <= start_addr_i;
            issue_cnt <= '0;
          end
        end
        scope_pkg::RD_RUN:
        begin
          rd_addr_q <= rd_addr_q + 1'b1;  // wraps around the ring
          issue_cnt <= issue_cnt + 1'b1;
          if (issue_last)
            state <= scope_pkg::RD_IDLE;
        end
        default:
          state <= scope_pkg::RD_IDLE;
      endcase
    end
  end

  // only the trailing beat of a burst may land in RD_IDLE
  a_valid_tail: assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (rd_valid_o && state == scope_pkg::RD_IDLE) |=>
      !(rd_valid_o && state == scope_pkg::RD_IDLE));

endmodule

`default_nettype wire

// ==== design/scope_top.sv ====
`default_nettype none

module scope_top (
  input  wire                      adc_clk,
  input  wire                      rst_n_i,
  // adc pins
  input  wire scope_pkg::raw_word_t adc_a_i,
  input  wire scope_pkg::raw_word_t adc_b_i,
  // generator samples
  input  wire scope_pkg::sample_t   dac_a_i,
  input  wire scope_pkg::sample_t   dac_b_i,
  input  wire                      digital_loop_i,
  // trigger and capture control
  input  wire scope_pkg::sample_t   trig_level_i,
  input  wire scope_pkg::buf_addr_t post_len_i,     // at least 1
  input  wire                      arm_i,
  // dac pins
  output scope_pkg::dac_code_t      dac_a_o,
  output scope_pkg::dac_code_t      dac_b_o,
  // capture stream
  output logic                     captured_o,
  output logic                     rd_valid_o,
  output scope_pkg::sample_t        rd_a_o,
  output scope_pkg::sample_t        rd_b_o,
  output logic                     rd_last_o
);

  scope_pkg::sample_t   sample_a;    // front end -> buffer, every cycle
  scope_pkg::sample_t   sample_b;
  scope_pkg::buf_addr_t start_addr;  // oldest pair of the window
  scope_pkg::buf_addr_t rd_addr;

  //////////////////////////////////////////////////////////////////////
  // analog front end
  //////////////////////////////////////////////////////////////////////

  analog_io u_analog_io (
    .adc_clk        (adc_clk),
    .rst_n_i        (rst_n_i),
    .adc_a_i        (adc_a_i),
    .adc_b_i        (adc_b_i),
    .dac_a_i        (dac_a_i),
    .dac_b_i        (dac_b_i),
    .digital_loop_i (digital_loop_i),
    .sample_a_o     (sample_a),
    .sample_b_o     (sample_b),
    .dac_a_o        (dac_a_o),
    .dac_b_o        (dac_b_o)
  );

  // capture memory and trigger, done drives captured_o directly
  capture_buffer u_capture_buffer (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .sample_a_i   (sample_a),
    .sample_b_i   (sample_b),
    .trig_level_i (trig_level_i),
    .post_len_i   (post_len_i),
    .arm_i        (arm_i),
    .rd_addr_i    (rd_addr),
    .rd_finish_i  (rd_last_o),   // last beat releases the window
    .done_o       (captured_o),
    .start_addr_o (start_addr),
    .rd_a_o       (rd_a_o),
    .rd_b_o       (rd_b_o)
  );

  // readout sequencer
  capture_readout u_capture_readout (
    .adc_clk      (adc_clk),
    .rst_n_i      (rst_n_i),
    .done_i       (captured_o),
    .start_addr_i (start_addr),
    .rd_addr_o    (rd_addr),
    .rd_valid_o   (rd_valid_o),
    .rd_last_o    (rd_last_o)
  );

endmodule

`default_nettype wire

// ==== bench/tb_scope.sv ====
`default_nettype none

module tb_scope;
  timeunit 1ns;
  timeprecision 1ps;

  typedef enum {A_BELOW, A_RAMP, A_RANDOM} a_shape_t;  // channel a stimulus shape

  logic adc_clk = 1'b0;
  logic rst_n_i;
  scope_pkg::raw_word_t  adc_a_i, adc_b_i;
  scope_pkg::sample_t    dac_a_i, dac_b_i, trig_level_i, rd_a_o, rd_b_o;
  scope_pkg::buf_addr_t  post_len_i;
  logic                  digital_loop_i, arm_i, captured_o, rd_valid_o, rd_last_o;
  scope_pkg::dac_code_t  dac_a_o, dac_b_o;

  integer seed;
  int n_fail = 0;                    // wrong values
  int n_other = 0;                   // timeouts, protocol slips
  int n_drv = 0;
  int beat_cnt = 0;
  int cur_post = 1;
  int ramp_start, ramp_val;
  logic run_abort = 1'b0;            // sequence stops after a timeout
  a_shape_t a_mode = A_RANDOM;
  logic loop_mode = 1'b0;
  scope_pkg::sample_t cfg_level = '0;
  scope_pkg::sample_t exp_a[$];      // expected sample per driven cycle
  scope_pkg::sample_t exp_b[$];
  scope_pkg::sample_t win_a[scope_pkg::BUF_DEPTH];  // predicted window, oldest first
  scope_pkg::sample_t win_b[scope_pkg::BUF_DEPTH];
  scope_pkg::sample_t dac_a_prev, dac_a_last, dac_b_prev, dac_b_last, prev_a;

  always #5 adc_clk = ~adc_clk;

  scope_top u_scope_top (
    .adc_clk(adc_clk), .rst_n_i(rst_n_i), .adc_a_i(adc_a_i), .adc_b_i(adc_b_i),
    .dac_a_i(dac_a_i), .dac_b_i(dac_b_i), .digital_loop_i(digital_loop_i),
    .trig_level_i(trig_level_i), .post_len_i(post_len_i), .arm_i(arm_i),
    .dac_a_o(dac_a_o), .dac_b_o(dac_b_o), .captured_o(captured_o),
    .rd_valid_o(rd_valid_o), .rd_a_o(rd_a_o), .rd_b_o(rd_b_o), .rd_last_o(rd_last_o)
  );

  ///////////////////////////////////////////////////////////////////////
  // reference model
  ///////////////////////////////////////////////////////////////////////

  // negative slope with the offset at midscale
  function automatic scope_pkg::dac_code_t expect_code(input scope_pkg::sample_t s);
    int full;
    full = (1 << (scope_pkg::SAMPLE_W - 1)) - 1;  // code 0 is this positive value
    expect_code = scope_pkg::dac_code_t'(full - int'(s));
  endfunction

  // raw adc word -> two's complement, low reserved bits dropped
  function automatic scope_pkg::sample_t expect_sample(input scope_pkg::raw_word_t raw);
    scope_pkg::dac_code_t code;
    int full;
    code = raw[scope_pkg::RAW_W-1:scope_pkg::RAW_LSB];
    full = (1 << (scope_pkg::SAMPLE_W - 1)) - 1;
    expect_sample = scope_pkg::sample_t'(full - int'(code));
  endfunction

  // first rising crossing at or after from
  function automatic int find_trigger(input int from);
    find_trigger = -1;
    for (int i = from; i < exp_a.size(); i++)
      if (find_trigger < 0 && exp_a[i-1] < cfg_level && exp_a[i] >= cfg_level)
        find_trigger = i;
  endfunction

  task automatic check_sample(input scope_pkg::sample_t got, input scope_pkg::sample_t exp,
                              input string what);
    if (got !== exp)
    begin
      n_fail++;
      $display("FAILED %0t ns: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_code(input scope_pkg::dac_code_t got, input scope_pkg::dac_code_t exp,
                            input string what);
    if (got !== exp)
    begin
      n_fail++;
      $display("FAILED %0t ns: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp)
    begin
      n_fail++;
      $display("FAILED %0t ns: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic end_run();
    $display("errors: %0d value mismatches, %0d other", n_fail, n_other);
    if (n_fail == 0 && n_other == 0)
      $display("TB PASSED");
    else
      $display("TB FAILED");
    $finish;
  endtask

  ///////////////////////////////////////////////////////////////////////
  // stimulus, one pair per clock
  ///////////////////////////////////////////////////////////////////////

  // drive on the rising edge, return at the falling edge where outputs are stable
  task automatic drive_cycle(input logic arm);
    int v;
    logic [1:0] low2;
    scope_pkg::sample_t a_s, b_s, d_a, d_b;
    scope_pkg::raw_word_t raw_a, raw_b;
    @(posedge adc_clk);
    v = $random(seed) & 32'h7ff;
    case (a_mode)
      A_BELOW:  a_s = scope_pkg::sample_t'(int'(cfg_level) - 1 - v);  // never crosses
      A_RAMP:
      begin
        a_s = scope_pkg::sample_t'(ramp_val);
        ramp_val += 5;
        if (ramp_val > int'(cfg_level) + 50)
          a_mode = A_RANDOM;
      end
      default:  a_s = scope_pkg::sample_t'($random(seed));
    endcase
    b_s   = scope_pkg::sample_t'($random(seed));
    low2  = 2'($random(seed));
    raw_b = scope_pkg::raw_word_t'($random(seed));
    if (loop_mode)
    begin
      d_a   = a_s;  // adc pins are don't care in loopback
      d_b   = b_s;
      raw_a = scope_pkg::raw_word_t'($random(seed));
      exp_a.push_back(d_a);
      exp_b.push_back(d_b);
    end
    else
    begin
      d_a   = scope_pkg::sample_t'($random(seed));
      d_b   = scope_pkg::sample_t'($random(seed));
      raw_a = {expect_code(a_s), low2};
      exp_a.push_back(expect_sample(raw_a));
      exp_b.push_back(expect_sample(raw_b));
    end
    adc_a_i        <= raw_a;
    adc_b_i        <= raw_b;
    dac_a_i        <= d_a;
    dac_b_i        <= d_b;
    digital_loop_i <= loop_mode;
    trig_level_i   <= cfg_level;
    post_len_i     <= scope_pkg::buf_addr_t'(cur_post);
    arm_i          <= arm;
    dac_a_prev = dac_a_last;
    dac_b_prev = dac_b_last;
    dac_a_last = d_a;
    dac_b_last = d_b;
    n_drv++;
    @(negedge adc_clk);
    if (n_drv >= 2)
    begin
      check_code(dac_a_o, expect_code(dac_a_prev), "dac_a_o");  // one edge of latency
      check_code(dac_b_o, expect_code(dac_b_prev), "dac_b_o");
    end
  endtask

  task automatic wait_captured(input int limit);
    int n;
    n = 0;
    while (!captured_o && n < limit)
    begin
      drive_cycle(1'b0);
      n++;
    end
    if (!captured_o)
    begin
      n_other++;
      run_abort = 1'b1;
      $display("timeout: captured_o did not rise within %0d cycles", limit);
    end
  endtask

  task automatic wait_stream(input int limit);
    int n;
    n = 0;
    while (beat_cnt < scope_pkg::BUF_DEPTH && n < limit)
    begin
      drive_cycle(1'b0);
      n++;
    end
    if (beat_cnt < scope_pkg::BUF_DEPTH)
    begin
      n_other++;
      run_abort = 1'b1;
      $display("timeout: only %0d readout beats after %0d cycles", beat_cnt, limit);
    end
  endtask

  // window = last BUF_DEPTH pairs, trigger pair at BUF_DEPTH - post
  task automatic build_window();
    int t, first;
    t = find_trigger(ramp_start);
    if (t < 0)
    begin
      n_other++;
      run_abort = 1'b1;
      $display("no trigger crossing found in the driven samples");
    end
    else
    begin
      first = t - (scope_pkg::BUF_DEPTH - cur_post);
      for (int j = 0; j < scope_pkg::BUF_DEPTH; j++)
      begin
        win_a[j] = exp_a[first + j];
        win_b[j] = exp_b[first + j];
      end
    end
  endtask

  task automatic run_capture(input logic loop, input scope_pkg::sample_t level, input int post);
    loop_mode = loop;
    cfg_level = level;
    cur_post  = post;
    a_mode    = A_BELOW;
    repeat (8) drive_cycle(1'b0);  // let mode and level settle
    beat_cnt = 0;
    drive_cycle(1'b1);
    repeat (scope_pkg::BUF_DEPTH + 80)
    begin
      drive_cycle(1'b0);
      check_flag(captured_o, 1'b0, "captured_o before trigger");
    end
    ramp_start = exp_a.size();
    ramp_val   = int'(level) - 50;
    a_mode     = A_RAMP;
    wait_captured(scope_pkg::BUF_DEPTH + 100);
    if (!run_abort)
      build_window();
    if (!run_abort)
      wait_stream(scope_pkg::BUF_DEPTH + 100);
    if (!run_abort)
    begin
      repeat (8) drive_cycle(1'b0);
      check_flag(captured_o, 1'b0, "captured_o after readout");
      if (beat_cnt != scope_pkg::BUF_DEPTH)
      begin
        n_other++;
        $display("stream had %0d beats instead of %0d", beat_cnt, scope_pkg::BUF_DEPTH);
      end
    end
  endtask

  ///////////////////////////////////////////////////////////////////////
  // compare process, one check per readout beat
  ///////////////////////////////////////////////////////////////////////

  always @(negedge adc_clk)
  begin
    if (rst_n_i && rd_valid_o)
    begin
      if (beat_cnt >= scope_pkg::BUF_DEPTH)
      begin
        n_other++;
        $display("extra readout beat past the window at %0t ns", $time);
      end
      else
      begin
        check_sample(rd_a_o, win_a[beat_cnt], $sformatf("beat %0d rd_a_o", beat_cnt));
        check_sample(rd_b_o, win_b[beat_cnt], $sformatf("beat %0d rd_b_o", beat_cnt));
        check_flag(rd_last_o, beat_cnt == scope_pkg::BUF_DEPTH - 1, "rd_last_o");
        // crossing must sit exactly at the pre-trigger boundary
        if (beat_cnt == scope_pkg::BUF_DEPTH - cur_post &&
            !(prev_a < cfg_level && rd_a_o >= cfg_level))
        begin
          n_fail++;
          $display("FAILED %0t ns: beat %0d is not the trigger pair", $time, beat_cnt);
        end
      end
      prev_a = rd_a_o;
      beat_cnt++;
    end
    else if (rst_n_i && rd_last_o)
    begin
      n_other++;
      $display("rd_last_o pulsed without rd_valid_o at %0t ns", $time);
    end
  end

  initial
  begin
    seed = 55;
    rst_n_i = 1'b0;
    adc_a_i = '0;
    adc_b_i = '0;
    dac_a_i = '0;
    dac_b_i = '0;
    digital_loop_i = 1'b0;
    trig_level_i = '0;
    post_len_i = 10'd1;
    arm_i = 1'b0;
    repeat (16) @(posedge adc_clk);
    rst_n_i <= 1'b1;
    // quiet until armed, dac codes checked every cycle from here on
    repeat (64)
    begin
      drive_cycle(1'b0);
      check_flag(captured_o, 1'b0, "captured_o idle");
      check_flag(rd_valid_o, 1'b0, "rd_valid_o idle");
      check_flag(rd_last_o, 1'b0, "rd_last_o idle");
    end
    run_capture(1'b0, 14'sd1000, 300);
    if (!run_abort)
      run_capture(1'b1, -14'sd500, 512);   // loopback
    if (!run_abort)
      run_capture(1'b0, 14'sd1000, 700);   // trigger pair moves
    if (!run_abort)
    begin
      // no crossing, window never completes
      loop_mode = 1'b0;
      a_mode    = A_BELOW;
      cur_post  = 200;
      repeat (8) drive_cycle(1'b0);
      drive_cycle(1'b1);
      repeat (scope_pkg::BUF_DEPTH + 400)
      begin
        drive_cycle(1'b0);
        check_flag(captured_o, 1'b0, "captured_o without trigger");
        check_flag(rd_valid_o, 1'b0, "rd_valid_o without trigger");
      end
    end
    end_run();
  end

endmodule

`default_nettype wire

// ==== src.f ====
design/scope_pkg.sv
design/analog_io.sv
design/capture_buffer.sv
design/capture_readout.sv
design/scope_top.sv
bench/tb_scope.sv

// ==== run.sh ====
#!/bin/sh
# build and run tb_scope with Verilator, the log decides pass or fail
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
  -f src.f --top-module tb_scope -Mdir obj_dir > build.log 2>&1 \
  || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_scope > sim.log 2>&1
cat sim.log
grep -q "TB FAILED" sim.log && exit 1
grep -q "TB PASSED" sim.log || exit 1
exit 0
